// File: imuldiv_op_pkg.sv
// ----------------------------------------------------------------------
// multiply/divide operation codes and the layout of the 64-bit result
// ----------------------------------------------------------------------

package imuldiv_op_pkg;

  // width of the function field in a request
  localparam int fn_width = 2;

  // function codes
  // signed multiply, full 64-bit product
  localparam logic [fn_width-1:0] fn_mul = 2'd0;
  // signed divide, truncating
  localparam logic [fn_width-1:0] fn_div = 2'd1;
  // unsigned divide
  localparam logic [fn_width-1:0] fn_divu = 2'd2;

  // divide result layout
  // quotient sits in the low half
  localparam int quo_lsb = 0;
  // remainder sits in the high half
  localparam int rem_lsb = 32;

endpackage

// File: imuldiv_width_pkg.sv
// ----------------------------------------------------------------------
// datapath widths and iteration count for the multiply/divide unit
// ----------------------------------------------------------------------

package imuldiv_width_pkg;

  // operand width
  localparam int xlen = 32;

  // result width, product or remainder plus quotient
  localparam int rlen = 64;

  // one operand bit retired per iteration
  localparam int iter_count = 32;

  // iteration counter width
  localparam int cnt_width = 6;

endpackage

// File: imuldiv_req_decode.sv
// ----------------------------------------------------------------------
// request decode: accepts one op at a time, forms operand magnitudes
// and sign flags, then starts the multiplier or the divider
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module imuldiv_req_decode (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  logic [imuldiv_op_pkg::fn_width-1:0] req_fn,
  input  logic [imuldiv_width_pkg::xlen-1:0]  req_a,
  input  logic [imuldiv_width_pkg::xlen-1:0]  req_b,
  input  logic                                op_retire,
  output logic                                mul_start,
  output logic                                div_start,
  output logic [imuldiv_width_pkg::xlen-1:0]  mag_a,
  output logic [imuldiv_width_pkg::xlen-1:0]  mag_b,
  output logic                                neg_lo,
  output logic                                neg_hi,
  output logic                                neg_all
);

  logic busy;
  logic accept;
  logic is_mul;
  logic is_signed;
  logic sign_a;
  logic sign_b;

  // one op in flight, held off until the response leaves
  assign req_rdy = ~busy;
  assign accept  = req_val & req_rdy;

  // spare code 3 falls through to an unsigned divide
  assign is_mul    = (req_fn == imuldiv_op_pkg::fn_mul);
  assign is_signed = is_mul | (req_fn == imuldiv_op_pkg::fn_div);

  // operand signs only count for the signed functions
  assign sign_a = is_signed & req_a[imuldiv_width_pkg::xlen-1];
  assign sign_b = is_signed & req_b[imuldiv_width_pkg::xlen-1];

  // ---------------------------------------------------------------------
  // control: busy flag and start pulses
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      // starts are single-cycle, one edge after accept
      mul_start <= accept & is_mul;
      div_start <= accept & ~is_mul;
      if (accept) begin
        busy <= 1'b1;
      end else if (op_retire) begin
        busy <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------
  // operand magnitudes and sign flags, captured at accept
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      // two's complement magnitude, raw value for unsigned
      mag_a   <= sign_a ? (~req_a + 1'b1) : req_a;
      mag_b   <= sign_b ? (~req_b + 1'b1) : req_b;
      // product sign
      neg_all <= is_mul & (sign_a ^ sign_b);
      // quotient sign
      neg_lo  <= ~is_mul & (sign_a ^ sign_b);
      // remainder follows the dividend
      neg_hi  <= ~is_mul & sign_a;
    end
  end

endmodule

// File: int_mul_iterative.sv
// ----------------------------------------------------------------------
// iterative shift-add multiplier on unsigned magnitudes, one bit of
// the multiplier per cycle
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module int_mul_iterative (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               start,
  input  logic [imuldiv_width_pkg::xlen-1:0] mag_a,
  input  logic [imuldiv_width_pkg::xlen-1:0] mag_b,
  output logic                               done,
  output logic [imuldiv_width_pkg::rlen-1:0] raw
);

  // multiplicand, shifted left each iteration
  logic [imuldiv_width_pkg::rlen-1:0]      mcand;
  // multiplier, shifted right each iteration
  logic [imuldiv_width_pkg::xlen-1:0]      mplier;
  // running product
  logic [imuldiv_width_pkg::rlen-1:0]      acc;
  logic [imuldiv_width_pkg::rlen-1:0]      acc_next;
  // iteration counter
  logic [imuldiv_width_pkg::cnt_width-1:0] cnt;
  logic                                    running;
  logic                                    last_iter;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = mplier[0] ? (acc + mcand) : acc;

  assign last_iter = (int'(cnt) == imuldiv_width_pkg::iter_count - 1);

  // ---------------------------------------------------------------------
  // control: idle / run, done pulse on the last iteration
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      cnt     <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        // product is complete in acc once this edge lands
        if (last_iter) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (start) begin
      // zero-extend the multiplicand into the 64-bit shifter
      mcand  <= {{(imuldiv_width_pkg::rlen - imuldiv_width_pkg::xlen){1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (running) begin
      acc    <= acc_next;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // acc holds after the run, so raw is still valid with done
  assign raw = acc;

endmodule

// File: int_div_iterative.sv
// ----------------------------------------------------------------------
// iterative restoring divider on unsigned magnitudes, one quotient bit
// per cycle; result is remainder in the high half, quotient in the low
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module int_div_iterative (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               start,
  input  logic [imuldiv_width_pkg::xlen-1:0] mag_a,
  input  logic [imuldiv_width_pkg::xlen-1:0] mag_b,
  output logic                               done,
  output logic [imuldiv_width_pkg::rlen-1:0] raw
);

  // partial remainder
  logic [imuldiv_width_pkg::xlen-1:0]      rem;
  // dividend bits shift out the top, quotient bits shift in the bottom
  logic [imuldiv_width_pkg::xlen-1:0]      quo;
  logic [imuldiv_width_pkg::xlen-1:0]      divisor;
  // remainder with the next dividend bit appended
  logic [imuldiv_width_pkg::xlen:0]        shifted;
  // trial subtraction, one extra bit to catch a borrow
  logic [imuldiv_width_pkg::xlen+1:0]      diff;
  logic                                    fits;
  logic [imuldiv_width_pkg::cnt_width-1:0] cnt;
  logic                                    running;
  logic                                    last_iter;

  // ---------------------------------------------------------------------
  // trial subtract
  // ---------------------------------------------------------------------
  assign shifted = {rem, quo[imuldiv_width_pkg::xlen-1]};
  assign diff    = {1'b0, shifted} - {2'b00, divisor};
  // no borrow means the divisor goes in
  assign fits    = ~diff[imuldiv_width_pkg::xlen+1];

  // with a zero divisor every step fits: quotient all ones,
  // remainder ends up as the dividend

  assign last_iter = (int'(cnt) == imuldiv_width_pkg::iter_count - 1);

  // ---------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      cnt     <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (last_iter) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (start) begin
      rem     <= '0;
      quo     <= mag_a;
      divisor <= mag_b;
    end else if (running) begin
      if (fits) begin
        // restoring step keeps the difference, always below the divisor
        rem <= diff[imuldiv_width_pkg::xlen-1:0];
        quo <= {quo[imuldiv_width_pkg::xlen-2:0], 1'b1};
      end else begin
        // divisor too large, keep the shifted remainder
        rem <= shifted[imuldiv_width_pkg::xlen-1:0];
        quo <= {quo[imuldiv_width_pkg::xlen-2:0], 1'b0};
      end
    end
  end

  // remainder high, quotient low
  assign raw = {rem, quo};

endmodule

// File: imuldiv_resp_merge.sv
// ----------------------------------------------------------------------
// result stage: sign correction, response register and handshake
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module imuldiv_resp_merge (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mul_done,
  input  logic [imuldiv_width_pkg::rlen-1:0] mul_raw,
  input  logic                               div_done,
  input  logic [imuldiv_width_pkg::rlen-1:0] div_raw,
  input  logic                               neg_lo,
  input  logic                               neg_hi,
  input  logic                               neg_all,
  output logic                               resp_val,
  input  logic                               resp_rdy,
  output logic [imuldiv_width_pkg::rlen-1:0] resp_result,
  output logic                               op_retire
);

  logic [imuldiv_width_pkg::rlen-1:0] mul_fix;
  logic [imuldiv_width_pkg::rlen-1:0] div_fix;
  logic [imuldiv_width_pkg::xlen-1:0] quo_mag;
  logic [imuldiv_width_pkg::xlen-1:0] rem_mag;

  // product negates as one 64-bit value
  assign mul_fix = neg_all ? (~mul_raw + 1'b1) : mul_raw;

  // quotient and remainder negate independently
  assign quo_mag = div_raw[imuldiv_op_pkg::quo_lsb +: imuldiv_width_pkg::xlen];
  assign rem_mag = div_raw[imuldiv_op_pkg::rem_lsb +: imuldiv_width_pkg::xlen];

  always_comb begin
    div_fix = '0;
    div_fix[imuldiv_op_pkg::quo_lsb +: imuldiv_width_pkg::xlen] =
      neg_lo ? (~quo_mag + 1'b1) : quo_mag;
    div_fix[imuldiv_op_pkg::rem_lsb +: imuldiv_width_pkg::xlen] =
      neg_hi ? (~rem_mag + 1'b1) : rem_mag;
  end

  // response leaves on val and rdy together
  assign op_retire = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (mul_done | div_done) begin
      resp_val <= 1'b1;
    end else if (op_retire) begin
      resp_val <= 1'b0;
    end
  end

  // result only loads on done, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (mul_done) begin
      resp_result <= mul_fix;
    end else if (div_done) begin
      resp_result <= div_fix;
    end
  end

endmodule

// File: imuldiv_unit.sv
// ----------------------------------------------------------------------
// iterative multiply/divide unit: decode, shift-add multiplier,
// restoring divider and result stage
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module imuldiv_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  logic [imuldiv_op_pkg::fn_width-1:0] req_fn,
  input  logic [imuldiv_width_pkg::xlen-1:0]  req_a,
  input  logic [imuldiv_width_pkg::xlen-1:0]  req_b,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output logic [imuldiv_width_pkg::rlen-1:0]  resp_result
);

  logic                               mul_start;
  logic                               div_start;
  logic [imuldiv_width_pkg::xlen-1:0] mag_a;
  logic [imuldiv_width_pkg::xlen-1:0] mag_b;
  logic                               neg_lo;
  logic                               neg_hi;
  logic                               neg_all;
  logic                               mul_done;
  logic [imuldiv_width_pkg::rlen-1:0] mul_raw;
  logic                               div_done;
  logic [imuldiv_width_pkg::rlen-1:0] div_raw;
  logic                               op_retire;

  // request side, owns the one-op-in-flight rule
  imuldiv_req_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req_fn    (req_fn),
    .req_a     (req_a),
    .req_b     (req_b),
    .op_retire (op_retire),
    .mul_start (mul_start),
    .div_start (div_start),
    .mag_a     (mag_a),
    .mag_b     (mag_b),
    .neg_lo    (neg_lo),
    .neg_hi    (neg_hi),
    .neg_all   (neg_all)
  );

  // both engines share the magnitudes, only one is started
  int_mul_iterative u_mul (
    .clk   (clk),
    .reset (reset),
    .start (mul_start),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .done  (mul_done),
    .raw   (mul_raw)
  );

  int_div_iterative u_div (
    .clk   (clk),
    .reset (reset),
    .start (div_start),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .done  (div_done),
    .raw   (div_raw)
  );

  imuldiv_resp_merge u_merge (
    .clk         (clk),
    .reset       (reset),
    .mul_done    (mul_done),
    .mul_raw     (mul_raw),
    .div_done    (div_done),
    .div_raw     (div_raw),
    .neg_lo      (neg_lo),
    .neg_hi      (neg_hi),
    .neg_all     (neg_all),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .op_retire   (op_retire)
  );

endmodule

// File: imuldiv_unit_asserts.sv
// ----------------------------------------------------------------------
// handshake, back-pressure and latency properties of the mul/div unit
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module imuldiv_unit_asserts (
  input logic                               clk,
  input logic                               reset,
  input logic                               req_val,
  input logic                               req_rdy,
  input logic                               resp_val,
  input logic                               resp_rdy,
  input logic [imuldiv_width_pkg::rlen-1:0] resp_result,
  input logic                               op_retire
);

  // count of failed properties over the whole run
  int fail_count = 0;

  // stalled response keeps its valid and its data
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin
      fail_count++;
      $error("response changed while resp_rdy was low");
    end

  // ready drops on accept and stays low until the op retires
  rdy_drop: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |=> !req_rdy)
    else begin
      fail_count++;
      $error("req_rdy still high after an accept");
    end

  rdy_busy: assert property (@(posedge clk) disable iff (reset)
    !req_rdy && !op_retire |=> !req_rdy)
    else begin
      fail_count++;
      $error("req_rdy rose before the op retired");
    end

  rdy_back: assert property (@(posedge clk) disable iff (reset)
    op_retire |=> req_rdy)
    else begin
      fail_count++;
      $error("req_rdy did not return after op_retire");
    end

  // 1 decode + 32 iterations + done + result register
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |-> !resp_val ##35 $rose(resp_val))
    else begin
      fail_count++;
      $error("resp_val did not rise 35 cycles after accept");
    end

  // idle state out of reset
  reset_state: assert property (@(posedge clk)
    reset |=> !resp_val && req_rdy)
    else begin
      fail_count++;
      $error("unit not idle after reset");
    end

endmodule

// File: imuldiv_unit_tb.sv
// ----------------------------------------------------------------------
// testbench for the multiply/divide unit: directed corners, random ops
// with response stalls, scoreboard check at every response transfer
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module imuldiv_unit_tb;

  localparam int num_ops        = 200;
  // 200 ops at about 44 cycles each, plus margin
  localparam int timeout_cycles = 12000;

  logic                                clk = 1'b0;
  logic                                reset;
  logic                                req_val;
  logic                                req_rdy;
  logic [imuldiv_op_pkg::fn_width-1:0] req_fn;
  logic [imuldiv_width_pkg::xlen-1:0]  req_a;
  logic [imuldiv_width_pkg::xlen-1:0]  req_b;
  logic                                resp_val;
  logic                                resp_rdy;
  logic [imuldiv_width_pkg::rlen-1:0]  resp_result;

  integer seed        = 71388;
  int     cycle_count = 0;
  int     op_count    = 0;
  int     err_count   = 0;
  int     test_ops    = 0;
  int     test_errs   = 0;

  imuldiv_unit u_imuldiv_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // protocol and latency properties, op_retire taken from inside the unit
  bind imuldiv_unit imuldiv_unit_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .op_retire   (op_retire)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, the unit stopped responding", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // reference model, built from the signed and unsigned arithmetic rules
  // ----------------------------------------------------------------------
  function automatic logic [63:0] expected_result(input logic [1:0] fn,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [31:0] q;
    logic [31:0] r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == imuldiv_op_pkg::fn_mul) begin
      return sa * sb;
    end
    if (b == '0) begin
      // all-ones quotient magnitude, remainder is the dividend
      q = (fn == imuldiv_op_pkg::fn_div && a[31]) ? 32'd1 : 32'hffff_ffff;
      r = a;
    end else if (fn == imuldiv_op_pkg::fn_div) begin
      // 64-bit math keeps min / -1 from overflowing
      q = 32'(sa / sb);
      r = 32'(sa % sb);
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  // one request, a random response stall, then the check at the transfer
  task automatic run_op(input logic [1:0] fn, input logic [31:0] a, input logic [31:0] b);
    logic [63:0] exp_result;
    int          stall;
    exp_result = expected_result(fn, a, b);
    stall      = $unsigned($random(seed)) % 9;
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    req_val <= 1'b0;
    while (!resp_val) @(posedge clk);
    repeat (stall) @(posedge clk);
    resp_rdy <= 1'b1;
    @(posedge clk);
    resp_rdy <= 1'b0;
    op_count++;
    test_ops++;
    assert (resp_result == exp_result) else begin
      $display("Fail at %0t: resp_result (fn %0d a %h b %h) expected %h actual %h",
               $time, fn, a, b, exp_result, resp_result);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d ops, %0d errors", name, test_ops, test_errs);
    test_ops  = 0;
    test_errs = 0;
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [1:0]  rfn;
    logic [31:0] ra;
    logic [31:0] rb;
    int          prop_fails;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = '0;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    run_op(imuldiv_op_pkg::fn_mul, 32'h0000_0000, 32'hffff_ffff);
    run_op(imuldiv_op_pkg::fn_mul, 32'h0000_0001, 32'h0000_0001);
    run_op(imuldiv_op_pkg::fn_mul, 32'hffff_ffff, 32'hffff_ffff);
    run_op(imuldiv_op_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000);
    run_op(imuldiv_op_pkg::fn_mul, 32'h7fff_ffff, 32'h8000_0000);
    report_test("signed multiply corners");
    // 7 / 2 in all four sign combinations, then min / -1
    run_op(imuldiv_op_pkg::fn_div, 32'h0000_0007, 32'h0000_0002);
    run_op(imuldiv_op_pkg::fn_div, 32'hffff_fff9, 32'h0000_0002);
    run_op(imuldiv_op_pkg::fn_div, 32'h0000_0007, 32'hffff_fffe);
    run_op(imuldiv_op_pkg::fn_div, 32'hffff_fff9, 32'hffff_fffe);
    run_op(imuldiv_op_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff);
    report_test("signed divide signs");
    run_op(imuldiv_op_pkg::fn_divu, 32'hffff_ffff, 32'h0000_0002);
    run_op(imuldiv_op_pkg::fn_divu, 32'hffff_fff0, 32'h8000_0001);
    report_test("unsigned divide");
    run_op(imuldiv_op_pkg::fn_div, 32'h0000_0005, 32'h0000_0000);
    run_op(imuldiv_op_pkg::fn_div, 32'hffff_fffb, 32'h0000_0000);
    run_op(imuldiv_op_pkg::fn_divu, 32'h8000_0000, 32'h0000_0000);
    report_test("divide by zero");
    while (op_count < num_ops) begin
      rfn = 2'($unsigned($random(seed)) % 3);
      ra  = $random(seed);
      rb  = $random(seed);
      // small divisor now and then, for long quotients
      if (rb[31:29] == 3'b000) begin
        rb = rb & 32'h0000_00ff;
      end
      run_op(rfn, ra, rb);
    end
    report_test("random operations");
    // protocol and timing properties checked alongside the data
    prop_fails = u_imuldiv_unit.u_asserts.fail_count;
    $display("ops checked %0d, errors %0d, property failures %0d",
             op_count, err_count, prop_fails);
    if (err_count == 0 && prop_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
imuldiv_op_pkg.sv
imuldiv_width_pkg.sv
imuldiv_req_decode.sv
int_mul_iterative.sv
int_div_iterative.sv
imuldiv_resp_merge.sv
imuldiv_unit.sv
imuldiv_unit_asserts.sv
imuldiv_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the multiply/divide unit testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module imuldiv_unit_tb -o imuldiv_unit_tb

./obj_dir/imuldiv_unit_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
